/* hw/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    localparam int XLEN = 32;
    localparam int FETCH_ID_BITS = 4;
    localparam int BTB_ENTRIES = 16;
    localparam int WFI_DELAY = 64;
    localparam int MEM_WORDS = 256;

    // tag that travels with each instruction toward decode.
    localparam logic [1:0] FAULT_NONE = 2'd0;
    localparam logic [1:0] FAULT_INTERRUPT = 2'd1;

    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // wfi is a system op with rd, rs1 and funct3 all zero.
    localparam logic [11:0] WFI_IMM = 12'h105;

    // one instruction word seen as a jump or as a system op.
    typedef union packed {
        struct packed {
            logic immSign;          // imm[20].
            logic [9:0] immLow;     // imm[10:1].
            logic immBit11;
            logic [7:0] immHigh;    // imm[19:12].
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } iType;
    } rvInstr_u;

endpackage

`default_nettype wire

/* hw/branchPredictor.sv */
`timescale 1ns/10ps
`default_nettype none

module branchPredictor #(
    parameter int xlen = fetchPkg::XLEN,
    parameter int btbEntries = fetchPkg::BTB_ENTRIES,
    parameter logic [xlen-1:0] resetPc = '0
) (
    input logic clk,
    input logic rst,
    input logic advance,
    input logic redirValid,
    input logic [xlen-1:0] redirDst,
    input logic extUpdValid,
    input logic [xlen-1:0] extUpdSrc,
    input logic [xlen-1:0] extUpdDst,
    input logic decUpdValid,
    input logic [xlen-1:0] decUpdSrc,
    input logic [xlen-1:0] decUpdDst,
    output logic [xlen-1:0] pc,
    output logic predTaken,
    output logic [xlen-1:0] predDst
);

    localparam int idxBits = $clog2(btbEntries);
    localparam int tagBits = xlen - idxBits - 2;

    logic [btbEntries-1:0] btbValid;
    logic [tagBits-1:0] btbTag [btbEntries];
    logic [xlen-1:0] btbDst [btbEntries];

    logic [idxBits-1:0] lookupIdx;
    logic updValid;
    logic [xlen-1:0] updSrc;
    logic [xlen-1:0] updDst;
    logic [idxBits-1:0] updIdx;

    // indexed by the low word-address bits.
    assign lookupIdx = pc[idxBits+1:2];
    assign predTaken = btbValid[lookupIdx] && (btbTag[lookupIdx] == pc[xlen-1:idxBits+2]);
    assign predDst = btbDst[lookupIdx];

    // the decode update is dropped when the external one fires.
    assign updValid = extUpdValid || decUpdValid;
    assign updSrc = extUpdValid ? extUpdSrc : decUpdSrc;
    assign updDst = extUpdValid ? extUpdDst : decUpdDst;
    assign updIdx = updSrc[idxBits+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (redirValid) begin
            pc <= redirDst;
        end else if (advance) begin
            pc <= predTaken ? predDst : pc + xlen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btbValid <= '0;
        end else if (updValid) begin
            btbValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            btbTag[updIdx] <= updSrc[xlen-1:idxBits+2];
            btbDst[updIdx] <= updDst;
        end
    end

    // a misaligned target would split every following fetch.
    redirAligned: assert property (
        @(posedge clk) disable iff (rst) redirValid |-> redirDst[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* hw/fetchPipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchPipeline #(
    parameter int fetchIdBits = fetchPkg::FETCH_ID_BITS
) (
    input logic clk,
    input logic rst,
    input logic issueValid,
    input logic [fetchPkg::XLEN-1:0] issuePc,
    input logic [1:0] issueFault,
    input logic issuePredTaken,
    input logic flush,
    input logic squashDec,
    output logic memRe,
    output logic [fetchPkg::XLEN-1:0] memAddr,
    input logic [fetchPkg::XLEN-1:0] memRData,
    output logic stall,
    output logic decRedirValid,
    output logic [fetchPkg::XLEN-1:0] decRedirDst,
    output logic decWfi,
    output logic pcfWe,
    output logic [fetchIdBits-1:0] pcfId,
    output logic [fetchPkg::XLEN-1:0] pcfPc,
    input logic [fetchIdBits-1:0] comFetchId,
    output logic outValid,
    input logic outReady,
    output logic [fetchPkg::XLEN-1:0] outInstr,
    output logic [fetchPkg::XLEN-1:0] outPc,
    output logic [fetchIdBits-1:0] outFetchId,
    output logic [1:0] outFault,
    output logic outPredTaken
);
    import fetchPkg::*;

    logic [fetchIdBits-1:0] nextId;
    logic reqValid;
    logic [XLEN-1:0] reqPc;
    logic [1:0] reqFault;
    logic reqPred;
    logic [fetchIdBits-1:0] reqId;
    logic rspValid;
    logic [XLEN-1:0] rspPc;
    logic [1:0] rspFault;
    logic rspPred;
    logic [fetchIdBits-1:0] rspId;
    logic outBusy;
    logic pipeStall;
    logic idFull;
    rvInstr_u rspInstr;
    logic isJal;
    logic isWfi;
    logic [XLEN-1:0] jalImm;

    assign outBusy = outValid && !outReady;
    assign pipeStall = rspValid && outBusy;
    assign idFull = fetchIdBits'(nextId + 1'b1) == comFetchId;   // window of IDs is full.
    assign stall = pipeStall || idFull;

    // memory keeps its read data while re is low, so a held response stays put.
    assign memRe = reqValid && !pipeStall;
    assign memAddr = reqPc;

    assign pcfWe = issueValid;
    assign pcfId = nextId;
    assign pcfPc = issuePc;

    assign rspInstr = memRData;
    assign isJal = rspInstr.jType.opcode == OPC_JAL;
    assign isWfi = rspInstr.iType.opcode == OPC_SYSTEM && rspInstr.iType.funct3 == 3'd0
        && rspInstr.iType.rs1 == 5'd0 && rspInstr.iType.rd == 5'd0
        && rspInstr.iType.imm12 == WFI_IMM;
    assign jalImm = {{(XLEN-20){rspInstr.jType.immSign}}, rspInstr.jType.immHigh,
        rspInstr.jType.immBit11, rspInstr.jType.immLow, 1'b0};

    // raised only as the word moves on, so a held word redirects once.
    assign decRedirValid = rspValid && !outBusy && rspFault == FAULT_NONE
        && ((isJal && !rspPred) || isWfi);
    assign decWfi = decRedirValid && isWfi;
    assign decRedirDst = rspPc + (isWfi ? XLEN'(4) : jalImm);

    always_ff @(posedge clk) begin
        if (rst) begin
            nextId <= '0;
        end else if (issueValid) begin
            nextId <= nextId + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            reqValid <= 1'b0;
            rspValid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (!pipeStall) begin
                reqValid <= issueValid;
                rspValid <= reqValid && !squashDec;   // drop the fetch behind a redirect.
            end
            if (!outBusy) begin
                outValid <= rspValid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pipeStall) begin
            reqPc <= issuePc;
            reqFault <= issueFault;
            reqPred <= issuePredTaken;
            reqId <= nextId;
            rspPc <= reqPc;
            rspFault <= reqFault;
            rspPred <= reqPred;
            rspId <= reqId;
        end
        if (!outBusy && rspValid) begin
            outInstr <= memRData;
            outPc <= rspPc;
            outFetchId <= rspId;
            outFault <= rspFault;
            outPredTaken <= rspPred;
        end
    end

    // the held response word is the one memory returned before the stall.
    rspWordHeld: assert property (
        @(posedge clk) disable iff (rst) pipeStall |=> $stable(memRData)
    );

    // a transferred instruction never comes out a second time.
    outNoRepeat: assert property (
        @(posedge clk) disable iff (rst) outValid && outReady && !flush
            |=> !outValid || outFetchId != $past(outFetchId)
    );

endmodule

`default_nettype wire

/* hw/pcFile.sv */
`timescale 1ns/10ps
`default_nettype none

module pcFile #(
    parameter int fetchIdBits = fetchPkg::FETCH_ID_BITS
) (
    input logic clk,
    input logic we,
    input logic [fetchIdBits-1:0] waddr,
    input logic [fetchPkg::XLEN-1:0] wdata,
    input logic re,
    input logic [fetchIdBits-1:0] raddr,
    output logic [fetchPkg::XLEN-1:0] rdata
);
    import fetchPkg::*;

    logic [XLEN-1:0] entries [2**fetchIdBits];

    // one entry per fetch ID, written at issue.
    always_ff @(posedge clk) begin
        if (we) begin
            entries[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= entries[raddr];   // one cycle read latency.
        end
    end

endmodule

`default_nettype wire

/* hw/instrFetch.sv */
`timescale 1ns/10ps
`default_nettype none

module instrFetch #(
    parameter int fetchIdBits = fetchPkg::FETCH_ID_BITS,
    parameter int btbEntries = fetchPkg::BTB_ENTRIES,
    parameter int wfiDelay = fetchPkg::WFI_DELAY,
    parameter logic [fetchPkg::XLEN-1:0] resetPc = '0
) (
    input logic clk,
    input logic rst,
    input logic en,
    input logic interruptPending,
    input logic redirValid,
    input logic [fetchPkg::XLEN-1:0] redirDst,
    input logic [fetchIdBits-1:0] redirFetchId,
    input logic btUpdValid,
    input logic [fetchPkg::XLEN-1:0] btUpdSrc,
    input logic [fetchPkg::XLEN-1:0] btUpdDst,
    input logic [fetchIdBits-1:0] comFetchId,
    input logic pcReadEn,
    input logic [fetchIdBits-1:0] pcReadId,
    output logic [fetchPkg::XLEN-1:0] pcReadData,
    output logic outValid,
    input logic outReady,
    output logic [fetchPkg::XLEN-1:0] outInstr,
    output logic [fetchPkg::XLEN-1:0] outPc,
    output logic [fetchIdBits-1:0] outFetchId,
    output logic [1:0] outFault,
    output logic outPredTaken,
    output logic memRe,
    output logic [fetchPkg::XLEN-1:0] memAddr,
    input logic [fetchPkg::XLEN-1:0] memRData
);
    import fetchPkg::*;

    localparam int cntBits = $clog2(wfiDelay + 1);

    logic [XLEN-1:0] pc;
    logic predTaken;
    logic stall;
    logic decRedirValid;
    logic [XLEN-1:0] decRedirDst;
    logic decWfi;
    logic pcfWe;
    logic [fetchIdBits-1:0] pcfId;
    logic [XLEN-1:0] pcfPc;
    logic waitForInterrupt;
    logic issuedInterrupt;
    logic [cntBits-1:0] wfiCount;
    logic baseEn;
    logic anyRedir;
    logic issueValid;
    logic [1:0] issueFault;
    logic squashDec;
    logic [XLEN-1:0] bpRedirDst;
    logic decUpdValid;
    logic [XLEN-1:0] decUpdDst;

    assign baseEn = en && !waitForInterrupt && !issuedInterrupt && !stall;
    assign anyRedir = redirValid || decRedirValid;
    assign issueValid = baseEn && !anyRedir;
    assign issueFault = interruptPending ? FAULT_INTERRUPT : FAULT_NONE;
    assign squashDec = decRedirValid && !redirValid;
    assign bpRedirDst = redirValid ? redirDst : decRedirDst;   // backend first.

    // the jal sits in the output register one cycle after its redirect.
    always_ff @(posedge clk) begin
        if (rst) begin
            decUpdValid <= 1'b0;
        end else begin
            decUpdValid <= squashDec && !decWfi;
        end
    end

    always_ff @(posedge clk) begin
        decUpdDst <= decRedirDst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            waitForInterrupt <= 1'b0;
            issuedInterrupt <= 1'b0;
        end else begin
            if (waitForInterrupt) begin
                wfiCount <= wfiCount - 1'b1;
                if (interruptPending || wfiCount == '0) begin
                    waitForInterrupt <= 1'b0;
                end
            end
            if (redirValid) begin
                waitForInterrupt <= 1'b0;
                issuedInterrupt <= 1'b0;
            end else if (decWfi) begin
                waitForInterrupt <= 1'b1;
                wfiCount <= cntBits'(wfiDelay - 1);
            end else if (issueValid && interruptPending) begin
                issuedInterrupt <= 1'b1;   // hold fetch until the backend redirects.
            end
        end
    end

    branchPredictor #(.xlen(XLEN), .btbEntries(btbEntries), .resetPc(resetPc)) bp (
        .clk(clk),
        .rst(rst),
        .advance(issueValid),
        .redirValid(anyRedir),
        .redirDst(bpRedirDst),
        .extUpdValid(btUpdValid),
        .extUpdSrc(btUpdSrc),
        .extUpdDst(btUpdDst),
        .decUpdValid(decUpdValid),
        .decUpdSrc(outPc),
        .decUpdDst(decUpdDst),
        .pc(pc),
        .predTaken(predTaken),
        .predDst()
    );

    fetchPipeline #(.fetchIdBits(fetchIdBits)) pipe (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issuePc(pc),
        .issueFault(issueFault),
        .issuePredTaken(predTaken),
        .flush(redirValid),
        .squashDec(squashDec),
        .memRe(memRe),
        .memAddr(memAddr),
        .memRData(memRData),
        .stall(stall),
        .decRedirValid(decRedirValid),
        .decRedirDst(decRedirDst),
        .decWfi(decWfi),
        .pcfWe(pcfWe),
        .pcfId(pcfId),
        .pcfPc(pcfPc),
        .comFetchId(comFetchId),
        .outValid(outValid),
        .outReady(outReady),
        .outInstr(outInstr),
        .outPc(outPc),
        .outFetchId(outFetchId),
        .outFault(outFault),
        .outPredTaken(outPredTaken)
    );

    pcFile #(.fetchIdBits(fetchIdBits)) pcf (
        .clk(clk),
        .we(pcfWe),
        .waddr(pcfId),
        .wdata(pcfPc),
        .re(pcReadEn),
        .raddr(pcReadId),
        .rdata(pcReadData)
    );

    // a redirect cycle leaves the request stage empty, so memory sees no read next.
    noIssueOnRedir: assert property (
        @(posedge clk) disable iff (rst) (redirValid || decRedirValid) |=> !memRe
    );

    // the backend can only redirect on a fetch it has already taken.
    redirFromTaken: assert property (
        @(posedge clk) disable iff (rst) redirValid && outValid |-> redirFetchId != outFetchId
    );

endmodule

`default_nettype wire

/* hw/instrMem.sv */
`timescale 1ns/10ps
`default_nettype none

module instrMem #(
    parameter int memWords = fetchPkg::MEM_WORDS
) (
    input logic clk,
    input logic re,
    input logic [fetchPkg::XLEN-1:0] raddr,
    output logic [fetchPkg::XLEN-1:0] rdata,
    input logic we,
    input logic [fetchPkg::XLEN-1:0] waddr,
    input logic [fetchPkg::XLEN-1:0] wdata
);
    import fetchPkg::*;

    localparam int idxBits = $clog2(memWords);

    logic [XLEN-1:0] mem [memWords];
    logic [idxBits-1:0] rIdx;
    logic [idxBits-1:0] wIdx;

    // both ports take byte addresses, the word index wraps at memWords.
    assign rIdx = idxBits'(raddr[XLEN-1:2] % memWords);
    assign wIdx = idxBits'(waddr[XLEN-1:2] % memWords);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wIdx] <= wdata;
        end
    end

    // rdata keeps its last word while re is low.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[rIdx];
        end
    end

endmodule

`default_nettype wire

/* hw/fetchFrontend.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchFrontend #(
    parameter int fetchIdBits = fetchPkg::FETCH_ID_BITS,
    parameter int btbEntries = fetchPkg::BTB_ENTRIES,
    parameter int wfiDelay = fetchPkg::WFI_DELAY,
    parameter int memWords = fetchPkg::MEM_WORDS,
    parameter logic [fetchPkg::XLEN-1:0] resetPc = '0
) (
    input logic clk,
    input logic rst,
    input logic en,
    input logic interruptPending,
    input logic redirValid,
    input logic [fetchPkg::XLEN-1:0] redirDst,
    input logic [fetchIdBits-1:0] redirFetchId,
    input logic btUpdValid,
    input logic [fetchPkg::XLEN-1:0] btUpdSrc,
    input logic [fetchPkg::XLEN-1:0] btUpdDst,
    input logic [fetchIdBits-1:0] comFetchId,
    input logic pcReadEn,
    input logic [fetchIdBits-1:0] pcReadId,
    output logic [fetchPkg::XLEN-1:0] pcReadData,
    output logic outValid,
    input logic outReady,
    output logic [fetchPkg::XLEN-1:0] outInstr,
    output logic [fetchPkg::XLEN-1:0] outPc,
    output logic [fetchIdBits-1:0] outFetchId,
    output logic [1:0] outFault,
    output logic outPredTaken,
    input logic memWe,
    input logic [fetchPkg::XLEN-1:0] memAddr,
    input logic [fetchPkg::XLEN-1:0] memWData
);
    import fetchPkg::*;

    logic fetchRe;
    logic [XLEN-1:0] fetchAddr;
    logic [XLEN-1:0] fetchRData;

    instrFetch #(
        .fetchIdBits(fetchIdBits),
        .btbEntries(btbEntries),
        .wfiDelay(wfiDelay),
        .resetPc(resetPc)
    ) ifetch (
        .clk(clk),
        .rst(rst),
        .en(en),
        .interruptPending(interruptPending),
        .redirValid(redirValid),
        .redirDst(redirDst),
        .redirFetchId(redirFetchId),
        .btUpdValid(btUpdValid),
        .btUpdSrc(btUpdSrc),
        .btUpdDst(btUpdDst),
        .comFetchId(comFetchId),
        .pcReadEn(pcReadEn),
        .pcReadId(pcReadId),
        .pcReadData(pcReadData),
        .outValid(outValid),
        .outReady(outReady),
        .outInstr(outInstr),
        .outPc(outPc),
        .outFetchId(outFetchId),
        .outFault(outFault),
        .outPredTaken(outPredTaken),
        .memRe(fetchRe),
        .memAddr(fetchAddr),
        .memRData(fetchRData)
    );

    // fill port shares the array with the fetch read.
    instrMem #(.memWords(memWords)) imem (
        .clk(clk),
        .re(fetchRe),
        .raddr(fetchAddr),
        .rdata(fetchRData),
        .we(memWe),
        .waddr(memAddr),
        .wdata(memWData)
    );

endmodule

`default_nettype wire

/* tb/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod = 50,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;   // reset drops on a rising edge.
    end

endmodule

`default_nettype wire

/* tb/fetchTb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchTb;
    import fetchPkg::*;

    localparam int NROWS = 6;
    localparam logic [31:0] NOP = 32'h00000013;
    localparam logic [31:0] WFI = 32'h10500073;

    logic clk, rst, en, interruptPending, redirValid, btUpdValid, pcReadEn;
    logic outValid, outReady, outPredTaken, memWe;
    logic [31:0] redirDst, btUpdSrc, btUpdDst, pcReadData, outInstr, outPc, memAddr, memWData;
    logic [3:0] redirFetchId, comFetchId, pcReadId, outFetchId;
    logic [1:0] outFault;

    // stimulus table.
    string rowName [NROWS];
    logic [31:0] rowStart [NROWS];
    int rowLen [NROWS];
    logic [31:0] rowProg [NROWS][4];
    bit rowRandom [NROWS];
    int rowInt [NROWS];
    bit rowUpd [NROWS];
    logic [31:0] rowUpdSrc [NROWS];
    logic [31:0] rowUpdDst [NROWS];
    int rowCount [NROWS];

    // reference model state.
    logic [31:0] modelMem [256];
    bit btbV [16];
    logic [31:0] btbSrc [16];
    logic [31:0] btbDst [16];
    logic [31:0] expPc [32];
    bit expPred [32];
    logic [1:0] expFault [32];
    bit expSkip [32];

    logic [31:0] pendPc [$];
    int pendDue [$];
    int seed, cycleNo, rowCycle, curInt, cur, got, extra, checks, errors;
    bit curRandom, timedOut;
    logic [3:0] lastId;

    clockGen clkGen (.clk(clk), .rst(rst));

    fetchFrontend UUT (
        .clk(clk), .rst(rst), .en(en), .interruptPending(interruptPending),
        .redirValid(redirValid), .redirDst(redirDst), .redirFetchId(redirFetchId),
        .btUpdValid(btUpdValid), .btUpdSrc(btUpdSrc), .btUpdDst(btUpdDst),
        .comFetchId(comFetchId), .pcReadEn(pcReadEn), .pcReadId(pcReadId),
        .pcReadData(pcReadData), .outValid(outValid), .outReady(outReady),
        .outInstr(outInstr), .outPc(outPc), .outFetchId(outFetchId), .outFault(outFault),
        .outPredTaken(outPredTaken), .memWe(memWe), .memAddr(memAddr), .memWData(memWData)
    );

    function automatic logic [31:0] makeJal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        if (expVal !== actVal) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic setupTable();
        for (int r = 0; r < NROWS; r++) begin
            rowLen[r] = 0;
            rowRandom[r] = 1'b0;
            rowInt[r] = 0;
            rowUpd[r] = 1'b0;
        end
        rowName[0] = "sequential";
        rowStart[0] = 32'h100;
        rowCount[0] = 12;
        rowName[1] = "jal first";
        rowStart[1] = 32'h200;
        rowCount[1] = 6;
        rowLen[1] = 2;
        rowProg[1][0] = NOP;
        rowProg[1][1] = makeJal(21'd12);
        rowName[2] = "jal predicted";
        rowStart[2] = 32'h200;
        rowCount[2] = 6;
        rowName[3] = "btb update";
        rowStart[3] = 32'h300;
        rowCount[3] = 6;
        rowUpd[3] = 1'b1;
        rowUpdSrc[3] = 32'h308;
        rowUpdDst[3] = 32'h340;
        rowName[4] = "backpressure";
        rowStart[4] = 32'h380;
        rowCount[4] = 10;
        rowRandom[4] = 1'b1;
        rowLen[4] = 3;
        rowProg[4][0] = NOP;
        rowProg[4][1] = NOP;
        rowProg[4][2] = makeJal(-21'sd8);
        rowName[5] = "wfi interrupt";
        rowStart[5] = 32'h3c0;
        rowCount[5] = 4;
        rowInt[5] = 25;
        rowLen[5] = 3;
        rowProg[5][0] = NOP;
        rowProg[5][1] = NOP;
        rowProg[5][2] = WFI;
    endtask

    // walks the program by the fetch rules, training the model btb on the way.
    task automatic buildExpected(input int r);
        logic [31:0] pc, w, imm;
        logic [3:0] idx;
        bit hit, intrNext;
        pc = rowStart[r];
        intrNext = 1'b0;
        for (int k = 0; k < rowCount[r]; k++) begin
            expPc[k] = pc;
            expFault[k] = intrNext ? FAULT_INTERRUPT : FAULT_NONE;
            idx = pc[5:2];
            hit = btbV[idx] && btbSrc[idx] == pc;
            expPred[k] = hit;
            expSkip[k] = 1'b0;
            intrNext = 1'b0;
            w = modelMem[pc[9:2]];
            if (hit) begin
                pc = btbDst[idx];
            end else if (w[6:0] == 7'b1101111) begin
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                btbV[idx] = 1'b1;
                btbSrc[idx] = pc;
                btbDst[idx] = pc + imm;
                expSkip[k] = 1'b1;   // the fetch behind the jump is squashed.
                pc = pc + imm;
            end else begin
                if (w == WFI) begin
                    expSkip[k] = 1'b1;
                    intrNext = rowInt[r] != 0;
                end
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic stepCycle();
        logic [3:0] expId;
        @(posedge clk);
        cycleNo++;
        rowCycle++;
        if (pendDue.size() > 0 && pendDue[0] == cycleNo) begin
            checkValue("pcReadData", pendPc.pop_front(), pcReadData);
            void'(pendDue.pop_front());
        end
        redirValid <= 1'b0;
        btUpdValid <= 1'b0;
        pcReadEn <= 1'b0;
        memWe <= 1'b0;
        outReady <= curRandom ? seed[0] : 1'b1;
        if (curRandom) seed = $random(seed);
        if (curInt != 0 && rowCycle == curInt) interruptPending <= 1'b1;
        if (outValid && outReady) begin
            comFetchId <= outFetchId + 4'd1;   // retire follows one cycle late.
            if (got < rowCount[cur]) begin
                checkValue("outPc", expPc[got], outPc);
                checkValue("outInstr", modelMem[expPc[got][9:2]], outInstr);
                checkValue("outPredTaken", expPred[got], outPredTaken);
                checkValue("outFault", expFault[got], outFault);
                if (got > 0) begin
                    expId = lastId + (expSkip[got-1] ? 4'd2 : 4'd1);
                    checkValue("outFetchId", expId, outFetchId);
                end
                pcReadEn <= 1'b1;
                pcReadId <= outFetchId;
                pendPc.push_back(expPc[got]);
                pendDue.push_back(cycleNo + 2);
                if (outFault == FAULT_INTERRUPT) interruptPending <= 1'b0;
                lastId = outFetchId;
                got++;
            end else begin
                extra++;
            end
        end
    endtask

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        stepCycle();
        memWe <= 1'b1;
        memAddr <= addr;
        memWData <= data;
        modelMem[addr[9:2]] = data;
    endtask

    task automatic runRow(input int r, output bit failed);
        int timer, errStart;
        failed = 1'b0;
        errStart = errors;
        cur = r;
        got = 0;
        extra = 0;
        for (int i = 0; i < rowLen[r]; i++) writeWord(rowStart[r] + 4 * i, rowProg[r][i]);
        if (rowUpd[r]) begin
            stepCycle();
            btUpdValid <= 1'b1;
            btUpdSrc <= rowUpdSrc[r];
            btUpdDst <= rowUpdDst[r];
            btbV[rowUpdSrc[r][5:2]] = 1'b1;
            btbSrc[rowUpdSrc[r][5:2]] = rowUpdSrc[r];
            btbDst[rowUpdSrc[r][5:2]] = rowUpdDst[r];
        end
        buildExpected(r);
        stepCycle();
        redirValid <= 1'b1;
        redirDst <= rowStart[r];
        redirFetchId <= lastId;
        en <= 1'b1;
        curRandom = rowRandom[r];
        curInt = rowInt[r];
        rowCycle = 0;
        timer = 0;
        while (got < rowCount[r] && timer < 400) begin
            stepCycle();
            timer++;
        end
        if (got < rowCount[r]) begin
            $display("test %0d (%s) timed out with %0d of %0d outputs",
                r, rowName[r], got, rowCount[r]);
            failed = 1'b1;
        end else begin
            if (rowInt[r] != 0) begin
                repeat (20) stepCycle();
                checkValue("extraOutputs", 0, extra);   // fetch stays blocked.
            end
            en <= 1'b0;
            redirValid <= 1'b1;
            redirDst <= rowStart[r];
            redirFetchId <= lastId;
            interruptPending <= 1'b0;
            curInt = 0;
            repeat (3) stepCycle();
            $display("test %0d (%s): %0d outputs, %0d errors",
                r, rowName[r], got, errors - errStart);
        end
    endtask

    initial begin
        int timer;
        en = 1'b0;
        interruptPending = 1'b0;
        redirValid = 1'b0;
        redirDst = '0;
        redirFetchId = '0;
        btUpdValid = 1'b0;
        btUpdSrc = '0;
        btUpdDst = '0;
        comFetchId = '0;
        pcReadEn = 1'b0;
        pcReadId = '0;
        outReady = 1'b1;
        memWe = 1'b0;
        memAddr = '0;
        memWData = '0;
        seed = 32'he81e29b1;
        cycleNo = 0;
        rowCycle = 0;
        curInt = 0;
        cur = 0;
        curRandom = 1'b0;
        checks = 0;
        errors = 0;
        lastId = '0;
        timedOut = 1'b0;
        for (int i = 0; i < 16; i++) btbV[i] = 1'b0;
        setupTable();
        // addi words that carry their own index, never a jump or a system op.
        for (int i = 0; i < 256; i++) begin
            writeWord(32'(i * 4), {4'h0, 8'(i), 5'd0, 3'd0, 5'd1, 7'h13});
        end
        timer = 0;
        while (rst && timer < 20) begin
            stepCycle();
            timer++;
        end
        if (rst) begin
            $display("reset never released");
            timedOut = 1'b1;
        end
        for (int r = 0; r < NROWS && !timedOut; r++) runRow(r, timedOut);
        $display("checks %0d, errors %0d", checks, errors);
        if (!timedOut && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/fetchPkg.sv
hw/branchPredictor.sv
hw/fetchPipeline.sv
hw/pcFile.sv
hw/instrFetch.sv
hw/instrMem.sv
hw/fetchFrontend.sv
tb/clockGen.sv
tb/fetchTb.sv
